//--- Makefile
SRCS := $(wildcard logic/*.sv tests/*.sv)

all: run

obj_dir/Vtlb_tb: all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tlb_tb -f all.f -o Vtlb_tb

run: obj_dir/Vtlb_tb
	obj_dir/Vtlb_tb | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- all.f
logic/tlb_pkg.sv
logic/tlb_way.sv
logic/tlb_way_merge.sv
logic/page_walker.sv
logic/tlb_ctrl.sv
logic/tlb_top.sv
tests/page_table_mem.sv
tests/tlb_tb.sv

//--- logic/page_walker.sv
// page walker: reads one page-table block over the tagged bus in eight beats
module page_walker (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [63:0] blk_addr,
	input  logic bus_reqack,
	input  logic bus_respcyc,
	input  logic [tlb_pkg::bus_data_bits-1:0] bus_resp,
	input  logic [tlb_pkg::bus_tag_bits-1:0] bus_resptag,
	output logic bus_reqcyc,
	output logic [tlb_pkg::bus_data_bits-1:0] bus_req,
	output logic [tlb_pkg::bus_tag_bits-1:0] bus_reqtag,
	output logic bus_respack,
	output logic done,
	output logic [tlb_pkg::line_bits-1:0] line
);

	tlb_pkg::walk_state_t state;
	logic [tlb_pkg::blk_bits-1:0] beat;
	logic beat_ok;
	logic last_beat;

	assign bus_reqtag = tlb_pkg::walk_tag;
	assign done = (state == tlb_pkg::ws_done);

	// beats with a foreign tag belong to someone else
	assign beat_ok = (state == tlb_pkg::ws_collect) && bus_respcyc &&
		(bus_resptag == tlb_pkg::walk_tag);
	assign last_beat = (beat == tlb_pkg::blk_bits'(tlb_pkg::blk_entries - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= tlb_pkg::ws_idle;
			bus_reqcyc <= 1'b0;
			bus_respack <= 1'b0;
			beat <= '0;
		end else begin
			bus_respack <= beat_ok; // ack each captured beat
			case (state)
				tlb_pkg::ws_idle: begin
					if (start) begin
						bus_reqcyc <= 1'b1;
						beat <= '0;
						state <= tlb_pkg::ws_request;
					end
				end
				tlb_pkg::ws_request: begin
					if (bus_reqack) begin
						bus_reqcyc <= 1'b0;
						state <= tlb_pkg::ws_collect;
					end
				end
				tlb_pkg::ws_collect: begin
					if (beat_ok) begin
						beat <= beat + 1'b1;
						if (last_beat) begin
							state <= tlb_pkg::ws_done;
						end
					end
				end
				default: begin
					state <= tlb_pkg::ws_idle; // done lasts one cycle
				end
			endcase
		end
	end

	// address and line payload
	always_ff @(posedge clk) begin
		if (state == tlb_pkg::ws_idle && start) begin
			bus_req <= blk_addr;
		end
		if (beat_ok) begin
			line[beat * tlb_pkg::entry_bits +: tlb_pkg::entry_bits] <= bus_resp;
		end
	end

	// controller keeps one walk in flight
	a_start_idle: assert property (
		@(posedge clk) disable iff (reset) start |-> state == tlb_pkg::ws_idle
	) else $error("walk started while busy");

endmodule

//--- logic/tlb_ctrl.sv
// tlb controller: accepts lookups, runs walks on a miss, fills and responds
module tlb_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  logic [63:0] v_addr,
	input  logic flush,
	input  logic [63:0] ptbr,
	input  logic hit,
	input  logic [63:0] pte,
	input  logic hit_way,
	input  logic victim,
	input  logic walk_done,
	input  logic [tlb_pkg::line_bits-1:0] walk_line,
	output tlb_pkg::lookup_t look,
	output tlb_pkg::fill_t fill,
	output logic touch,
	output logic touch_way,
	output logic walk_start,
	output logic [63:0] blk_addr,
	output logic resp_valid,
	output logic [63:0] p_addr,
	output logic flush_go
);

	tlb_pkg::ctrl_state_t state;
	tlb_pkg::lookup_t req_look;
	tlb_pkg::lookup_t miss_look;
	logic miss_victim;
	logic [tlb_pkg::page_bits-1:0] miss_off;
	logic flush_pend;
	logic accept;
	logic fill_now;
	logic [63:0] fill_pte;

	// physical page number lives in entry bits 63:10
	function automatic logic [63:0] make_paddr(
		input logic [63:0] entry,
		input logic [tlb_pkg::page_bits-1:0] off
	);
		logic [63:0] ppn;
		ppn = 64'(entry[63:10]);
		return (ppn << tlb_pkg::page_bits) + 64'(off);
	endfunction

	assign req_look = v_addr[tlb_pkg::page_bits +: $bits(tlb_pkg::lookup_t)];
	assign look = (state == tlb_pkg::cs_idle) ? req_look : miss_look;

	assign accept = (state == tlb_pkg::cs_idle) && req;
	assign walk_start = accept && !hit;
	// 8-byte entries, so one block number step is 64 bytes
	assign blk_addr = ptbr + (64'({req_look.tag, req_look.set}) << (tlb_pkg::blk_bits + 3));

	assign fill_now = (state == tlb_pkg::cs_walk) && walk_done;
	assign fill.we = fill_now ? {miss_victim, ~miss_victim} : 2'b00;
	assign fill.set = miss_look.set;
	assign fill.tag = miss_look.tag;
	assign fill.line = walk_line;
	assign fill_pte = walk_line[miss_look.blk * tlb_pkg::entry_bits +: tlb_pkg::entry_bits];

	assign touch = (accept && hit) || fill_now;
	assign touch_way = fill_now ? miss_victim : hit_way;

	// flush waits for an idle cycle with no request
	assign flush_go = (flush || flush_pend) && (state == tlb_pkg::cs_idle) && !req;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= tlb_pkg::cs_idle;
			resp_valid <= 1'b0;
			flush_pend <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			if (flush_go) begin
				flush_pend <= 1'b0;
			end else if (flush) begin
				flush_pend <= 1'b1;
			end
			case (state)
				tlb_pkg::cs_idle: begin
					if (accept) begin
						resp_valid <= hit;
						state <= hit ? tlb_pkg::cs_respond : tlb_pkg::cs_walk;
					end
				end
				tlb_pkg::cs_walk: begin
					if (walk_done) begin
						resp_valid <= 1'b1;
						state <= tlb_pkg::cs_fill;
					end
				end
				default: begin
					state <= tlb_pkg::cs_idle; // response cycle
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (walk_start) begin
			miss_look <= req_look;
			miss_victim <= victim;
			miss_off <= v_addr[tlb_pkg::page_bits-1:0];
		end
		if (accept && hit) begin
			p_addr <= make_paddr(pte, v_addr[tlb_pkg::page_bits-1:0]);
		end else if (fill_now) begin
			p_addr <= make_paddr(fill_pte, miss_off);
		end
	end

	// requester drops req in the response cycle
	a_req_dropped: assert property (
		@(posedge clk) disable iff (reset) resp_valid |-> !req
	) else $error("req still high after resp_valid");

endmodule

//--- logic/tlb_pkg.sv
// tlb package: TLB geometry, bus widths, shared structs and FSM encodings
package tlb_pkg;

	// geometry
	localparam int num_sets = 64;
	localparam int set_bits = 6;
	localparam int tag_bits = 27;
	localparam int blk_entries = 8;
	localparam int blk_bits = 3;
	localparam int page_bits = 12;
	localparam int entry_bits = 64; // one page-table entry
	localparam int line_bits = 512; // one block of eight entries

	// memory bus
	localparam int bus_data_bits = 64;
	localparam int bus_tag_bits = 13;
	localparam logic [bus_tag_bits-1:0] walk_tag = 13'h0a5; // tag used for every walk read

	typedef struct packed {
		logic [tag_bits-1:0] tag;
		logic [set_bits-1:0] set;
		logic [blk_bits-1:0] blk;
	} lookup_t;

	typedef struct packed {
		logic hit;
		logic [entry_bits-1:0] pte;
	} way_result_t;

	typedef struct packed {
		logic [1:0] we; // one bit per way
		logic [set_bits-1:0] set;
		logic [tag_bits-1:0] tag;
		logic [line_bits-1:0] line;
	} fill_t;

	typedef enum logic [1:0] {
		ws_idle,
		ws_request,
		ws_collect,
		ws_done
	} walk_state_t;

	typedef enum logic [1:0] {
		cs_idle,
		cs_respond,
		cs_walk,
		cs_fill
	} ctrl_state_t;

endpackage

//--- logic/tlb_top.sv
// tlb top: two ways, way merge, controller and page walker
module tlb_top (
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  logic [63:0] v_addr,
	input  logic flush,
	input  logic [63:0] ptbr,
	output logic resp_valid,
	output logic [63:0] p_addr,
	output logic bus_reqcyc,
	output logic bus_respack,
	output logic [tlb_pkg::bus_data_bits-1:0] bus_req,
	output logic [tlb_pkg::bus_tag_bits-1:0] bus_reqtag,
	input  logic bus_respcyc,
	input  logic bus_reqack,
	input  logic [tlb_pkg::bus_data_bits-1:0] bus_resp,
	input  logic [tlb_pkg::bus_tag_bits-1:0] bus_resptag
);

	tlb_pkg::lookup_t look;
	tlb_pkg::fill_t fill;
	tlb_pkg::way_result_t res0;
	tlb_pkg::way_result_t res1;
	logic hit;
	logic [63:0] pte;
	logic hit_way;
	logic victim;
	logic touch;
	logic touch_way;
	logic flush_go;
	logic walk_start;
	logic [63:0] blk_addr;
	logic walk_done;
	logic [tlb_pkg::line_bits-1:0] walk_line;

	tlb_ctrl u_ctrl (
		.clk(clk), .reset(reset), .req(req), .v_addr(v_addr), .flush(flush), .ptbr(ptbr),
		.hit(hit), .pte(pte), .hit_way(hit_way), .victim(victim),
		.walk_done(walk_done), .walk_line(walk_line),
		.look(look), .fill(fill), .touch(touch), .touch_way(touch_way),
		.walk_start(walk_start), .blk_addr(blk_addr),
		.resp_valid(resp_valid), .p_addr(p_addr), .flush_go(flush_go)
	);

	tlb_way u_way0 (
		.clk(clk), .reset(reset), .flush(flush_go),
		.look(look), .fill(fill), .way_id(1'b0), .result(res0)
	);

	tlb_way u_way1 (
		.clk(clk), .reset(reset), .flush(flush_go),
		.look(look), .fill(fill), .way_id(1'b1), .result(res1)
	);

	tlb_way_merge u_merge (
		.clk(clk), .reset(reset), .flush(flush_go), .set(look.set),
		.res0(res0), .res1(res1), .touch(touch), .touch_way(touch_way),
		.hit(hit), .pte(pte), .hit_way(hit_way), .victim(victim)
	);

	page_walker u_walker (
		.clk(clk), .reset(reset), .start(walk_start), .blk_addr(blk_addr),
		.bus_reqack(bus_reqack), .bus_respcyc(bus_respcyc),
		.bus_resp(bus_resp), .bus_resptag(bus_resptag),
		.bus_reqcyc(bus_reqcyc), .bus_req(bus_req), .bus_reqtag(bus_reqtag),
		.bus_respack(bus_respack), .done(walk_done), .line(walk_line)
	);

endmodule

//--- logic/tlb_way.sv
// tlb way: tag, valid and line storage of one way with lookup and fill write
module tlb_way (
	input  logic clk,
	input  logic reset,
	input  logic flush,
	input  tlb_pkg::lookup_t look,
	input  tlb_pkg::fill_t fill,
	input  logic way_id,
	output tlb_pkg::way_result_t result
);

	logic [tlb_pkg::tag_bits-1:0] tag_mem [tlb_pkg::num_sets];
	logic [tlb_pkg::line_bits-1:0] line_mem [tlb_pkg::num_sets];
	logic [tlb_pkg::num_sets-1:0] valid;
	logic [tlb_pkg::line_bits-1:0] rd_line;
	logic [tlb_pkg::tag_bits-1:0] rd_tag;
	logic wr_en;

	assign wr_en = fill.we[way_id]; // each way owns one enable bit

	// combinational read of the indexed set
	assign rd_line = line_mem[look.set];
	assign rd_tag = tag_mem[look.set];

	assign result.hit = valid[look.set] && (rd_tag == look.tag);
	assign result.pte = rd_line[look.blk * tlb_pkg::entry_bits +: tlb_pkg::entry_bits];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
		end else if (flush) begin
			valid <= '0; // drop every entry
		end else if (wr_en) begin
			valid[fill.set] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_mem[fill.set] <= fill.tag;
			line_mem[fill.set] <= fill.line;
		end
	end

endmodule

//--- logic/tlb_way_merge.sv
// way merge: picks the hitting way, tracks per-set LRU and names the victim
module tlb_way_merge (
	input  logic clk,
	input  logic reset,
	input  logic flush,
	input  logic [tlb_pkg::set_bits-1:0] set,
	input  tlb_pkg::way_result_t res0,
	input  tlb_pkg::way_result_t res1,
	input  logic touch,
	input  logic touch_way,
	output logic hit,
	output logic [63:0] pte,
	output logic hit_way,
	output logic victim
);

	logic [tlb_pkg::num_sets-1:0] lru; // 1 means way 1 is least recently used

	assign hit = res0.hit || res1.hit;
	assign hit_way = res1.hit;
	assign pte = res1.hit ? res1.pte : res0.pte;
	assign victim = lru[set];

	always_ff @(posedge clk) begin
		if (reset) begin
			lru <= '0;
		end else if (flush) begin
			lru <= '0; // way 0 goes first after a flush
		end else if (touch) begin
			lru[set] <= ~touch_way; // other way becomes LRU
		end
	end

	// a tag lives in at most one way of a set
	a_one_way_hits: assert property (
		@(posedge clk) disable iff (reset) !(res0.hit && res1.hit)
	) else $error("both ways hit in set %0d", set);

endmodule

//--- tests/page_table_mem.sv
// page table memory: bus responder returning entries from an address formula
module page_table_mem (
	input  logic clk,
	input  logic reset,
	input  logic bus_reqcyc,
	input  logic [63:0] bus_req,
	input  logic [12:0] bus_reqtag,
	output logic bus_reqack,
	output logic bus_respcyc,
	output logic [63:0] bus_resp,
	output logic [12:0] bus_resptag
);
	timeunit 1ns;
	timeprecision 100ps;

	// page number stored in the entry at byte address a
	function automatic logic [53:0] entry_ppn(input logic [63:0] a);
		return 54'((a >> 3) * 64'd7 + 64'h1234);
	endfunction

	task automatic serve_block();
		logic [63:0] addr;
		logic [12:0] tag;
		addr = bus_req;
		tag = bus_reqtag;
		repeat ($urandom_range(0, 5)) @(negedge clk);
		bus_reqack = 1'b1;
		@(negedge clk);
		bus_reqack = 1'b0;
		for (int i = 0; i < 8; i++) begin
			repeat ($urandom_range(0, 5)) @(negedge clk); // gap before beat
			bus_respcyc = 1'b1;
			bus_resp = {entry_ppn(addr + 64'(i * 8)), 10'h000};
			bus_resptag = tag;
			@(negedge clk);
			bus_respcyc = 1'b0;
		end
	endtask

	initial begin
		bus_reqack = 1'b0;
		bus_respcyc = 1'b0;
		bus_resp = '0;
		bus_resptag = '0;
		forever begin
			@(negedge clk);
			if (!reset && bus_reqcyc) begin
				serve_block();
			end
		end
	end

endmodule

//--- tests/tlb_tb.sv
// tlb testbench: directed and random translations checked against a reference model
module tlb_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk = 1'b0;
	logic reset;
	logic req;
	logic [63:0] v_addr;
	logic flush;
	logic [63:0] ptbr;
	logic resp_valid;
	logic [63:0] p_addr;
	logic bus_reqcyc, bus_respack, bus_reqack, bus_respcyc;
	logic [63:0] bus_req, bus_resp;
	logic [12:0] bus_reqtag, bus_resptag;

	int errors = 0;
	int checks = 0;
	int failed_tests = 0;
	int test_start_errors;
	int bus_reqs = 0;
	int bus_at_start;
	logic exp_hit;
	logic [63:0] exp_paddr;
	logic [63:0] exp_blk;
	logic beat_prev = 1'b0;

	// shadow of the TLB contents
	logic [26:0] sh_tag [2][64];
	logic sh_valid [2][64];
	logic sh_lru [64];

	always #5 clk = ~clk;

	tlb_top UUT (.*);
	page_table_mem u_mem (.*);

	function automatic logic [53:0] entry_ppn(input logic [63:0] a);
		return 54'((a >> 3) * 64'd7 + 64'h1234);
	endfunction

	function automatic logic [63:0] expect_paddr(input logic [63:0] base, input logic [63:0] va);
		logic [63:0] a;
		a = base + {25'h0, va[47:15], 6'h00} + {58'h0, va[14:12], 3'h0};
		return (64'(entry_ppn(a)) << 12) + 64'(va[11:0]);
	endfunction

	function automatic logic [63:0] make_va(input int tag, input int set, input int blk, input int off);
		return (64'(tag) << 21) | (64'(set) << 15) | (64'(blk) << 12) | 64'(off);
	endfunction

	// bus block address check at acknowledge
	always @(posedge clk) begin
		if (!reset && bus_reqcyc && bus_reqack) begin
			bus_reqs++;
			checks++;
			assert (bus_req == exp_blk) else begin
				errors++;
				$display("Error at %0t: bus_req %h, expected %h", $time, bus_req, exp_blk);
			end
		end
	end

	// every beat is acked in the following cycle
	always @(posedge clk) begin
		beat_prev <= !reset && bus_respcyc;
	end

	always @(negedge clk) begin
		if (!reset && (beat_prev || bus_respack)) begin
			checks++;
			assert (bus_respack == beat_prev) else begin
				errors++;
				$display("Error at %0t: bus_respack %0b, expected %0b", $time,
					bus_respack, beat_prev);
			end
		end
	end

	// compare process
	always @(negedge clk) begin
		if (!reset && resp_valid) begin
			checks += 2;
			assert (p_addr == exp_paddr) else begin
				errors++;
				$display("Error at %0t: p_addr %h, expected %h", $time, p_addr, exp_paddr);
			end
			assert ((bus_reqs - bus_at_start) == (exp_hit ? 0 : 1)) else begin
				errors++;
				$display("Error at %0t: %0d bus requests, expected hit %0b", $time,
					bus_reqs - bus_at_start, exp_hit);
			end
		end
	end

	task automatic clear_shadow();
		for (int s = 0; s < 64; s++) begin
			sh_valid[0][s] = 1'b0;
			sh_valid[1][s] = 1'b0;
			sh_lru[s] = 1'b0;
		end
	endtask

	// want: 0 miss, 1 hit, 2 take the shadow model's word
	task automatic translate(input logic [63:0] va, input int want);
		logic [5:0] s;
		logic [26:0] t;
		logic pred;
		logic way;
		logic got;
		int n;
		s = va[20:15];
		t = va[47:21];
		pred = 1'b0;
		way = sh_lru[s];
		for (int w = 0; w < 2; w++) begin
			if (sh_valid[w][s] && sh_tag[w][s] == t) begin
				pred = 1'b1;
				way = w[0];
			end
		end
		exp_hit = (want == 2) ? pred : want[0];
		exp_paddr = expect_paddr(ptbr, va);
		exp_blk = ptbr + {25'h0, va[47:15], 6'h00};
		bus_at_start = bus_reqs;
		req = 1'b1;
		v_addr = va;
		got = 1'b0;
		n = 0;
		while (!got && n < 400) begin
			@(negedge clk);
			n++;
			got = resp_valid;
		end
		req = 1'b0;
		if (!got) begin
			$display("timeout: no resp_valid for virtual address %h", va);
			$display("*** FAILED ***");
			$finish;
		end else begin
			if (exp_hit) begin
				checks++;
				assert (n == 1) else begin
					errors++;
					$display("Error at %0t: hit latency %0d cycles, expected 1", $time, n);
				end
			end else begin
				sh_valid[way][s] = 1'b1; // fill the victim
				sh_tag[way][s] = t;
			end
			sh_lru[s] = ~way;
			@(negedge clk);
		end
	endtask

	task automatic pulse_flush();
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		@(negedge clk);
		clear_shadow();
	endtask

	task automatic end_test(input string name);
		if (errors == test_start_errors) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	initial begin
		logic [63:0] va;
		int pool [4];
		void'($urandom(32'hb230));
		reset = 1'b1;
		req = 1'b0;
		v_addr = '0;
		flush = 1'b0;
		ptbr = 64'h0000_0040_0000_0000;
		clear_shadow();
		pool = '{3, 17, 1200, 77777};
		test_start_errors = 0;

		// reset
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			checks++;
			assert (!resp_valid && !bus_reqcyc && !bus_respack) else begin
				errors++;
				$display("Error at %0t: outputs active during reset", $time);
			end
		end
		reset = 1'b0;
		@(negedge clk);
		end_test("reset");

		translate(make_va(3, 1, 2, 'h123), 0);
		end_test("cold_miss");

		translate(make_va(3, 1, 6, 'hfff), 1);
		end_test("hit_after_fill");

		translate(make_va(10, 5, 0, 'h010), 0); // A
		translate(make_va(11, 5, 1, 'h020), 0); // B
		translate(make_va(10, 5, 2, 'h030), 1);
		translate(make_va(12, 5, 3, 'h040), 0); // C evicts B
		translate(make_va(10, 5, 4, 'h050), 1);
		translate(make_va(11, 5, 5, 'h060), 0);
		end_test("lru_replacement");

		translate(make_va(3, 1, 2, 'h123), 1);
		pulse_flush();
		translate(make_va(3, 1, 2, 'h123), 0);
		end_test("flush");

		for (int i = 0; i < 200; i++) begin
			va = make_va(pool[$urandom_range(0, 3)], $urandom_range(8, 11),
				$urandom_range(0, 7), $urandom_range(0, 4095));
			translate(va, 2);
		end
		end_test("random");

		$display("tests 6, failed %0d, checks %0d, errors %0d", failed_tests, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
